/* hdl/barrierPkg.sv */
`default_nettype none

package barrierPkg;

    ////////////////////
    // Basic types
    ////////////////////

    // Screen coordinate, covers up to 2047
    typedef logic [10:0] coordT;
    // Block health, 0 means destroyed
    typedef logic [1:0] healthT;
    // Pixel colour
    typedef logic [7:0] rgbT;

    ////////////////////
    // Field geometry
    ////////////////////

    // Blocks per barrier
    localparam int blockColCount = 4;
    localparam int blockRowCount = 4;
    // 8 pixel square blocks
    localparam int blockSizeLog2 = 3;

    // Barrier footprint in pixels, 32 by 32
    localparam int barrierWidth = blockColCount << blockSizeLog2;
    localparam int barrierHeight = blockRowCount << blockSizeLog2;

    // Placement on screen
    localparam int barrierLeft0 = 128;
    localparam int barrierPitch = 192;
    localparam int barrierTopY = 384;

    ////////////////////
    // Health and colour
    ////////////////////

    localparam int healthFull = 3;
    // Health lands in bits 5:4, base pattern in 3:0
    localparam int rgbHealthPos = 4;
    localparam int rgbBase = 8;

    // Width of a barrier index, never below one bit
    function automatic int idxWidth(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

endpackage

`default_nettype wire

/* hdl/blockAddrIf.sv */
`timescale 1ns/10ps
`default_nettype none

// Located block for one screen point
interface blockAddrIf import barrierPkg::*; #(
    parameter int numBarriers = 4
);

    // Point lies on an existing barrier footprint
    logic inBarrier;
    // Which barrier, counted from the left
    logic [idxWidth(numBarriers)-1:0] barrierIdx;
    // Block position inside the barrier
    logic [1:0] blockCol;
    logic [1:0] blockRow;

    // Coordinate decoder side
    modport locator (output inBarrier, output barrierIdx, output blockCol, output blockRow);

    // Health storage side
    modport field (input inBarrier, input barrierIdx, input blockCol, input blockRow);

endinterface

`default_nettype wire

/* hdl/barrierLocator.sv */
`timescale 1ns/10ps
`default_nettype none

// Coordinate to barrier block decoder, purely combinational
module barrierLocator import barrierPkg::*; #(
    parameter int numBarriers = 4
) (
    input coordT xCoord,
    input coordT yCoord,
    blockAddrIf.locator addr
);

    localparam int idxW = idxWidth(numBarriers);

    // Offsets from the field origin
    coordT xOff;
    coordT yOff;
    // Barrier number and position inside its pitch slot
    coordT barrierNum;
    coordT slotX;
    // Range checks
    logic xInRange;
    logic yInRange;

    ////////////////////
    // Horizontal
    ////////////////////

    always_comb begin
        xOff = xCoord - coordT'(barrierLeft0);
        // Constant divisor, pitch is not a power of two
        barrierNum = xOff / coordT'(barrierPitch);
        slotX = xOff % coordT'(barrierPitch);
        // Left of barrier 0 would wrap, so check the raw coordinate
        xInRange = (xCoord >= coordT'(barrierLeft0))
            && (slotX < coordT'(barrierWidth))
            && (barrierNum < coordT'(numBarriers));
    end

    ////////////////////
    // Vertical
    ////////////////////

    always_comb begin
        yOff = yCoord - coordT'(barrierTopY);
        // All barriers share one row
        yInRange = (yCoord >= coordT'(barrierTopY)) && (yOff < coordT'(barrierHeight));
    end

    // Drive the located address
    always_comb begin
        addr.inBarrier = xInRange && yInRange;
        addr.barrierIdx = barrierNum[idxW-1:0];
        // Block index is the offset in block units
        addr.blockCol = slotX[blockSizeLog2 +: 2];
        addr.blockRow = yOff[blockSizeLog2 +: 2];
    end

endmodule

`default_nettype wire

/* hdl/barrierField.sv */
`timescale 1ns/10ps
`default_nettype none

// Block health store for all barriers
// Pixel lookup and laser damage, one cycle of latency
module barrierField import barrierPkg::*; #(
    parameter int numBarriers = 4
) (
    input logic clk,
    input logic rstN,
    input logic [1:0] mode,
    blockAddrIf.field pixAddr,
    blockAddrIf.field laserAddr,
    output logic isBarrier,
    output rgbT rgb,
    output logic laserHit
);

    // Health per barrier, column, row
    healthT health [numBarriers][blockColCount][blockRowCount];

    // Restore in the two lowest modes
    logic restore;

    // Current health under the pixel and under the laser
    healthT pixHealth;
    healthT laserHealth;
    logic pixLive;
    logic laserLive;

    // Arch opening test, true for blocks that start empty
    function automatic logic isOpen(input int col, input int row);
        logic edgeCol;
        logic midCol;
        edgeCol = (col == 0) || (col == blockColCount - 1);
        midCol = (col == 1) || (col == 2);
        return (edgeCol && (row == blockRowCount - 1)) || (midCol && (row >= 2));
    endfunction

    // Starting health of one block
    function automatic healthT startHealth(input int col, input int row);
        return isOpen(col, row) ? healthT'(0) : healthT'(healthFull);
    endfunction

    assign restore = (mode == 2'd0) || (mode == 2'd1);

    ////////////////////
    // Lookups
    ////////////////////

    // Both reads see the stored value, damage lands at the edge
    assign pixHealth = health[pixAddr.barrierIdx][pixAddr.blockCol][pixAddr.blockRow];
    assign laserHealth = health[laserAddr.barrierIdx][laserAddr.blockCol][laserAddr.blockRow];

    // Live means on a footprint and not yet destroyed
    assign pixLive = pixAddr.inBarrier && (pixHealth != '0);
    assign laserLive = laserAddr.inBarrier && (laserHealth != '0);

    ////////////////////
    // Health update
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN || restore) begin
            // Rebuild the arch pattern on every barrier
            for (int b = 0; b < numBarriers; b++) begin
                for (int c = 0; c < blockColCount; c++) begin
                    for (int r = 0; r < blockRowCount; r++) begin
                        health[b][c][r] <= startHealth(c, r);
                    end
                end
            end
        end else if (laserLive) begin
            // One point of damage per cycle
            health[laserAddr.barrierIdx][laserAddr.blockCol][laserAddr.blockRow]
                <= laserHealth - healthT'(1);
        end
    end

    ////////////////////
    // Registered outputs
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rstN || restore) begin
            // Quiet while the field is rebuilt
            isBarrier <= 1'b0;
            rgb <= '0;
            laserHit <= 1'b0;
        end else begin
            isBarrier <= pixLive;
            // Health shows up in the colour, off blocks stay black
            if (pixLive) begin
                rgb <= rgbT'(rgbBase) | (rgbT'(pixHealth) << rgbHealthPos);
            end else begin
                rgb <= '0;
            end
            // Hit only when a block actually took damage
            laserHit <= laserLive;
        end
    end

endmodule

`default_nettype wire

/* hdl/barrierTop.sv */
`timescale 1ns/10ps
`default_nettype none

// Barrier field top level
// Pixel and laser coordinates in, registered pixel and hit out
module barrierTop import barrierPkg::*; #(
    parameter int numBarriers = 4
) (
    input logic clk,
    input logic rstN,
    input logic [1:0] mode,
    input coordT pixX,
    input coordT pixY,
    input coordT laserX,
    input coordT laserY,
    output logic isBarrier,
    output rgbT rgb,
    output logic laserHit
);

    ////////////////////
    // Located addresses
    ////////////////////

    // Block under the current display pixel
    blockAddrIf #(.numBarriers(numBarriers)) pixAddr ();
    // Block under the player laser
    blockAddrIf #(.numBarriers(numBarriers)) laserAddr ();

    barrierLocator #(.numBarriers(numBarriers)) pixLocator (
        .xCoord(pixX),
        .yCoord(pixY),
        .addr(pixAddr)
    );

    barrierLocator #(.numBarriers(numBarriers)) laserLocator (
        .xCoord(laserX),
        .yCoord(laserY),
        .addr(laserAddr)
    );

    ////////////////////
    // Health store
    ////////////////////

    barrierField #(.numBarriers(numBarriers)) field (
        .clk(clk),
        .rstN(rstN),
        .mode(mode),
        .pixAddr(pixAddr),
        .laserAddr(laserAddr),
        .isBarrier(isBarrier),
        .rgb(rgb),
        .laserHit(laserHit)
    );

endmodule

`default_nettype wire

/* tb/barrierField_assert.sv */
`timescale 1ns/10ps
`default_nettype none

// Properties of the barrier field outputs
module barrierFieldAssert import barrierPkg::*; (
    input logic clk,
    input logic rstN,
    input logic [1:0] mode,
    input logic isBarrier,
    input rgbT rgb,
    input logic laserHit
);

    // Reset or restore mode rebuilds the pattern
    logic restoring;

    // Property failures so far
    int failCount = 0;

    assign restoring = !rstN || (mode == 2'd0) || (mode == 2'd1);

    ////////////////////
    // Restore cycle
    ////////////////////

    // No hit right after a rebuild
    assert property (@(posedge clk) restoring |=> !laserHit)
        else begin
            $error("laserHit high in the cycle after a restore");
            failCount++;
        end

    // Display blank right after a rebuild
    assert property (@(posedge clk) restoring |=> (!isBarrier && rgb == '0))
        else begin
            $error("pixel output not blank after a restore");
            failCount++;
        end

    ////////////////////
    // Colour
    ////////////////////

    // Off pixels stay black
    assert property (@(posedge clk) disable iff (!rstN) !isBarrier |-> rgb == '0)
        else begin
            $error("rgb nonzero while isBarrier is low");
            failCount++;
        end

    // Live pixel carries a nonzero health over the base pattern
    assert property (@(posedge clk) disable iff (!rstN)
        isBarrier |-> (rgb[7:6] == 2'b00 && rgb[3:0] == 4'(rgbBase) && rgb[5:4] != 2'b00))
        else begin
            $error("rgb of a live block has the wrong form");
            failCount++;
        end

endmodule

`default_nettype wire

/* tb/barrierChecker.sv */
`timescale 1ns/10ps
`default_nettype none

// Result checker for the barrier field
// Lines up golden values with the registered outputs, compares on the falling edge
module barrierChecker import barrierPkg::*; (
    input logic clk,
    input logic lineValid,
    input logic [127:0] testName,
    input logic expIsBarrier,
    input rgbT expRgb,
    input logic expLaserHit,
    input logic allDone,
    input logic isBarrier,
    input rgbT rgb,
    input logic laserHit,
    output int linesChecked,
    output int mismatchCount,
    output logic summaryDone
);

    // Golden values delayed by the DUT latency
    logic validQ;
    logic [127:0] nameQ;
    logic expIsBarrierQ;
    rgbT expRgbQ;
    logic expLaserHitQ;
    logic doneQ;

    // Running test
    logic [127:0] curName;
    int curErrors;
    int curLines;
    // Totals
    int testCount;
    int testsWithErrors;

    initial begin
        validQ = 1'b0;
        doneQ = 1'b0;
        curName = '0;
        curErrors = 0;
        curLines = 0;
        testCount = 0;
        testsWithErrors = 0;
        linesChecked = 0;
        mismatchCount = 0;
        summaryDone = 1'b0;
    end

    // Packed name to printable text, leading zero bytes dropped
    function automatic string nameText(input logic [127:0] name);
        string s;
        logic [7:0] ch;
        s = "";
        for (int i = 15; i >= 0; i--) begin
            ch = name[i*8 +: 8];
            if (ch != 8'h00) begin
                s = $sformatf("%s%c", s, ch);
            end
        end
        return s;
    endfunction

    task automatic reportMismatch(input string field, input int expVal, input int actVal);
        $display("[FAIL] %s %s expected 0x%0h actual 0x%0h",
            nameText(nameQ), field, expVal, actVal);
        curErrors++;
        mismatchCount++;
    endtask

    // One line per finished test
    task automatic closeTest();
        testCount++;
        if (curErrors == 0) begin
            $display("test %s ok, %0d lines", nameText(curName), curLines);
        end else begin
            testsWithErrors++;
            $display("test %s had %0d mismatches over %0d lines",
                nameText(curName), curErrors, curLines);
        end
    endtask

    ////////////////////
    // Alignment
    ////////////////////

    always @(posedge clk) begin
        validQ <= lineValid;
        nameQ <= testName;
        expIsBarrierQ <= expIsBarrier;
        expRgbQ <= expRgb;
        expLaserHitQ <= expLaserHit;
        doneQ <= allDone;
    end

    ////////////////////
    // Compare
    ////////////////////

    // Outputs settled half a cycle after the edge
    always @(negedge clk) begin
        if (validQ) begin
            // New name starts a new test
            if (nameQ != curName) begin
                if (curName != '0) begin
                    closeTest();
                end
                curName = nameQ;
                curErrors = 0;
                curLines = 0;
            end
            curLines++;
            linesChecked++;
            if (isBarrier !== expIsBarrierQ) begin
                reportMismatch("isBarrier", int'(expIsBarrierQ), int'(isBarrier));
            end
            if (rgb !== expRgbQ) begin
                reportMismatch("rgb", int'(expRgbQ), int'(rgb));
            end
            if (laserHit !== expLaserHitQ) begin
                reportMismatch("laserHit", int'(expLaserHitQ), int'(laserHit));
            end
        end
        if (doneQ && !summaryDone) begin
            if (curName != '0) begin
                closeTest();
            end
            curName = '0;
            $display("summary: %0d tests, %0d with errors, %0d lines checked, %0d mismatches",
                testCount, testsWithErrors, linesChecked, mismatchCount);
            summaryDone <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb/barrierTb.sv */
`timescale 1ns/10ps
`default_nettype none

// Barrier field testbench
// Golden lines drive the DUT one per cycle
// Checker compares one cycle later
module barrierTb import barrierPkg::*; ();

    localparam int clkPeriod = 10;
    localparam int resetCycles = 3;
    // Headroom past the golden lines before the watchdog fires
    localparam int slackCycles = 20;
    localparam logic [31:0] randSeed = 32'h4c90_367b;
    localparam goldenPath = "tb/barrier_golden.txt";

    // Test name as packed text of up to 16 characters
    typedef logic [127:0] nameT;

    // One golden line with inputs then expected outputs
    typedef struct packed {
        nameT name;
        logic [1:0] mode;
        coordT pixX;
        coordT pixY;
        coordT laserX;
        coordT laserY;
        logic expIsBarrier;
        rgbT expRgb;
        logic expLaserHit;
    } goldenLineT;

    // DUT side
    logic clk;
    logic rstN;
    logic [1:0] mode;
    coordT pixX;
    coordT pixY;
    coordT laserX;
    coordT laserY;
    logic isBarrier;
    rgbT rgb;
    logic laserHit;

    // Checker side
    logic lineValid;
    nameT testName;
    logic expIsBarrier;
    rgbT expRgb;
    logic expLaserHit;
    logic allDone;
    int linesChecked;
    int mismatchCount;
    logic summaryDone;

    goldenLineT goldenQ[$];
    logic goldenLoaded;

    barrierTop #(.numBarriers(4)) DUT (
        .clk(clk),
        .rstN(rstN),
        .mode(mode),
        .pixX(pixX),
        .pixY(pixY),
        .laserX(laserX),
        .laserY(laserY),
        .isBarrier(isBarrier),
        .rgb(rgb),
        .laserHit(laserHit)
    );

    barrierChecker checkerInst (
        .clk(clk),
        .lineValid(lineValid),
        .testName(testName),
        .expIsBarrier(expIsBarrier),
        .expRgb(expRgb),
        .expLaserHit(expLaserHit),
        .allDone(allDone),
        .isBarrier(isBarrier),
        .rgb(rgb),
        .laserHit(laserHit),
        .linesChecked(linesChecked),
        .mismatchCount(mismatchCount),
        .summaryDone(summaryDone)
    );

    // Field level properties
    bind barrierField barrierFieldAssert fieldAssert (
        .clk(clk),
        .rstN(rstN),
        .mode(mode),
        .isBarrier(isBarrier),
        .rgb(rgb),
        .laserHit(laserHit)
    );

    ////////////////////
    // Clock
    ////////////////////

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Idle lines get a random laser position
    function automatic logic isFiller(input nameT name);
        return (name == nameT'("idleA")) || (name == nameT'("idleB"));
    endfunction

    ////////////////////
    // Golden file
    ////////////////////

    task automatic loadGolden(output bit ok);
        int fd;
        int fields;
        string lineStr;
        nameT nm;
        int m;
        int px;
        int py;
        int lx;
        int ly;
        int eb;
        int er;
        int eh;
        goldenLineT entry;
        ok = 1'b1;
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            $display("could not open golden file %s", goldenPath);
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                lineStr = "";
                void'($fgets(lineStr, fd));
                // Skip blank and comment lines
                if (lineStr.len() > 1) begin
                    if (lineStr[0] != "#") begin
                        fields = $sscanf(lineStr, "%s %d %d %d %d %d %d %h %d",
                            nm, m, px, py, lx, ly, eb, er, eh);
                        if (fields != 9) begin
                            $display("malformed golden line: %s", lineStr);
                            ok = 1'b0;
                        end else begin
                            entry.name = nm;
                            entry.mode = 2'(m);
                            entry.pixX = coordT'(px);
                            entry.pixY = coordT'(py);
                            entry.laserX = coordT'(lx);
                            entry.laserY = coordT'(ly);
                            entry.expIsBarrier = 1'(eb);
                            entry.expRgb = rgbT'(er);
                            entry.expLaserHit = 1'(eh);
                            goldenQ.push_back(entry);
                        end
                    end
                end
            end
            $fclose(fd);
            if (goldenQ.size() == 0) begin
                $display("golden file holds no stimulus lines");
                ok = 1'b0;
            end
        end
    endtask

    // Drive one line on the current rising edge
    task automatic applyLine(input goldenLineT entry);
        mode <= entry.mode;
        pixX <= entry.pixX;
        pixY <= entry.pixY;
        if (isFiller(entry.name)) begin
            // Anywhere above the barrier row
            laserX <= coordT'($urandom % 2048);
            laserY <= coordT'($urandom % barrierTopY);
        end else begin
            laserX <= entry.laserX;
            laserY <= entry.laserY;
        end
        lineValid <= 1'b1;
        testName <= entry.name;
        expIsBarrier <= entry.expIsBarrier;
        expRgb <= entry.expRgb;
        expLaserHit <= entry.expLaserHit;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        bit loadOk;
        int assertFails;
        rstN = 1'b0;
        mode = 2'd2;
        pixX = '0;
        pixY = '0;
        laserX = '0;
        laserY = '0;
        lineValid = 1'b0;
        testName = '0;
        expIsBarrier = 1'b0;
        expRgb = '0;
        expLaserHit = 1'b0;
        allDone = 1'b0;
        goldenLoaded = 1'b0;
        void'($urandom(randSeed));
        loadGolden(loadOk);
        if (!loadOk) begin
            $display("sim failed");
            $finish;
        end else begin
            goldenLoaded = 1'b1;
            repeat (resetCycles) @(posedge clk);
            rstN <= 1'b1;
            // First line goes out on the edge that releases reset
            foreach (goldenQ[i]) begin
                applyLine(goldenQ[i]);
                @(posedge clk);
            end
            lineValid <= 1'b0;
            allDone <= 1'b1;
            wait (summaryDone);
            assertFails = DUT.field.fieldAssert.failCount;
            if (mismatchCount == 0 && linesChecked == goldenQ.size()
                && assertFails == 0) begin
                $display("sim passed");
            end else begin
                if (linesChecked != goldenQ.size()) begin
                    $display("only %0d of %0d golden lines were checked",
                        linesChecked, goldenQ.size());
                end
                if (assertFails != 0) begin
                    $display("%0d field assertions failed", assertFails);
                end
                $display("sim failed");
            end
            $finish;
        end
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        wait (goldenLoaded);
        repeat (goldenQ.size() + slackCycles) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles",
            goldenQ.size() + slackCycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/barrier_golden.txt */
# name mode pixX pixY laserX laserY | expected isBarrier rgb(hex) laserHit, coordinates decimal
# lines named idleA or idleB get random laser coordinates above the barrier row
resetSolid 2 130 386 0 0 1 38 0
resetSolid 2 330 394 0 0 1 38 0
resetSolid 2 731 402 0 0 1 38 0
resetSolid 2 514 401 0 0 1 38 0
resetSolid 2 159 384 0 0 1 38 0
resetOpen 2 138 410 0 0 0 00 0
resetOpen 2 336 400 0 0 0 00 0
resetOpen 2 514 408 0 0 0 00 0
resetOpen 2 735 415 0 0 0 00 0
resetOpen 2 159 415 0 0 0 00 0
outside 2 127 390 0 0 0 00 0
outside 2 160 390 0 0 0 00 0
outside 2 130 383 0 0 0 00 0
outside 2 130 416 0 0 0 00 0
outside 2 896 390 0 0 0 00 0
outside 2 1500 390 0 0 0 00 0
outside 2 2047 2047 0 0 0 00 0
outside 2 0 0 0 0 0 00 0
idleA 2 0 0 0 0 0 00 0
idleA 2 0 0 0 0 0 00 0
idleA 2 0 0 0 0 0 00 0
laserHold 2 325 389 322 386 1 38 1
laserHold 2 325 389 322 386 1 28 1
laserHold 2 325 389 322 386 1 18 1
laserHold 2 325 389 322 386 0 00 0
laserHold 2 325 389 0 0 0 00 0
sameCycle 2 523 387 522 386 1 38 1
sameCycle 2 523 387 0 0 1 28 0
sameCycle 2 514 386 522 386 1 38 1
sameCycle 2 523 387 0 0 1 18 0
laserMiss 2 138 410 138 410 0 00 0
laserMiss 2 325 389 322 386 0 00 0
laserMiss 2 130 386 200 390 1 38 0
laserMiss 2 130 386 722 402 1 38 0
laserMiss 2 523 387 0 0 1 18 0
restore 1 325 389 0 0 0 00 0
restore 1 130 386 130 386 0 00 0
restore 2 325 389 0 0 1 38 0
restore 2 523 387 0 0 1 38 0
restore 2 130 386 0 0 1 38 0
restore 2 138 410 0 0 0 00 0
restore 0 330 394 0 0 0 00 0
restore 3 330 394 0 0 1 38 0
idleB 2 0 0 0 0 0 00 0
idleB 2 0 0 0 0 0 00 0

/* sources.f */
hdl/barrierPkg.sv
hdl/blockAddrIf.sv
hdl/barrierLocator.sv
hdl/barrierField.sv
hdl/barrierTop.sv
tb/barrierField_assert.sv
tb/barrierChecker.sv
tb/barrierTb.sv

/* run.sh */
#!/bin/sh
# Build and run the barrier field simulation with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --assert --top-module barrierTb -f sources.f \
    --Mdir "$BUILD_DIR" -o barrierSim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build returned status $status"
    exit 1
fi

"./$BUILD_DIR/barrierSim" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if grep -q "sim failed" "$SIM_LOG"; then
    exit 1
fi
if ! grep -q "sim passed" "$SIM_LOG"; then
    echo "simulation log holds no result"
    exit 1
fi
exit 0
